//--- rtl/ppu_pkg.sv
package ppu_pkg;

    // Screen and tile geometry
    localparam int TILES_PER_LINE = 40;
    localparam int TILE_SIZE = 16;
    localparam int TILES_PER_WORD = 4;
    localparam int WORDS_PER_ROW = 10;

    // Palette organisation
    localparam int PALETTE_ENTRIES = 8;
    localparam int COLORS_PER_PALETTE = 4;

    typedef logic [23:0] color_t;

    // Sixteen 2-bit pixels, pixel 0 in bits 31:30
    typedef logic [31:0] tile_gfx_t;

    // Four tile entries, entry k in byte k
    typedef logic [31:0] tile_word_t;

    typedef logic [6:0] tile_id_t;
    typedef logic [8:0] tile_addr_t;
    typedef logic [10:0] gfx_addr_t;
    typedef logic [2:0] pal_addr_t;
    typedef logic [1:0] pixel_t;
    typedef logic [5:0] tile_col_t;
    typedef logic [10:0] hcount_t;
    typedef logic [9:0] vcount_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RUN,
        FETCH_DONE
    } fetch_state_t;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_RUN,
        LOAD_DONE
    } load_state_t;

endpackage

//--- rtl/line_wr_if.sv
`timescale 1ns/1ps

interface line_wr_if;
    import ppu_pkg::*;

    logic valid;
    tile_col_t col;
    tile_gfx_t gfx;
    logic pal_sel;

    // Fetcher writes one entry per valid cycle
    modport fetch (
        output valid, col, gfx, pal_sel
    );

    // Buffer always accepts
    modport buffer (
        input valid, col, gfx, pal_sel
    );

endinterface

//--- rtl/palette_cache.sv
`timescale 1ns/1ps

module palette_cache (
    input  logic               clk,
    input  logic               reset,
    input  logic               vblank,
    input  ppu_pkg::color_t    pal_data,
    input  ppu_pkg::pal_addr_t lookup_index,
    output ppu_pkg::pal_addr_t pal_addr,
    output ppu_pkg::color_t    lookup_color
);
    import ppu_pkg::*;

    load_state_t state;
    color_t cache [PALETTE_ENTRIES];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOAD_IDLE;
            pal_addr <= '0;
            for (int i = 0; i < PALETTE_ENTRIES; i++) begin
                cache[i] <= '0;
            end
        end else if (!vblank) begin
            // Rearm for the next vertical blank
            state <= LOAD_IDLE;
            pal_addr <= '0;
        end else begin
            case (state)
                LOAD_IDLE: begin
                    pal_addr <= '0;
                    state <= LOAD_RUN;
                end
                LOAD_RUN: begin
                    // Data on the bus belongs to the address issued last cycle
                    cache[pal_addr] <= pal_data;
                    if (pal_addr == pal_addr_t'(PALETTE_ENTRIES - 1)) begin
                        pal_addr <= '0;
                        state <= LOAD_DONE;
                    end else begin
                        pal_addr <= pal_addr + 1'b1;
                    end
                end
                default: begin
                    pal_addr <= '0;
                end
            endcase
        end
    end

    // Combinational lookup for the pixel pipeline
    assign lookup_color = cache[lookup_index];

endmodule

//--- rtl/background_fetch.sv
`timescale 1ns/1ps

module background_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                vblank,
    input  logic                hsync,
    input  ppu_pkg::vcount_t    vcount,
    input  ppu_pkg::tile_word_t tile_data,
    input  ppu_pkg::tile_gfx_t  gfx_data,
    output ppu_pkg::tile_addr_t tile_addr,
    output ppu_pkg::gfx_addr_t  gfx_addr,
    line_wr_if.fetch            wr
);
    import ppu_pkg::*;

    fetch_state_t state;
    logic sync_mode;
    tile_addr_t row_base;
    logic [7:0] tile_entry;

    // Stage 1 holds the column whose tile word is on the bus
    logic s1_valid;
    tile_col_t s1_col;

    // Stage 2 holds the column whose graphics row is on the bus
    logic s2_valid;
    tile_col_t s2_col;
    logic s2_pal;

    assign sync_mode = hsync && !vblank;

    // First tile buffer word of the current tile row
    assign row_base = tile_addr_t'((vcount / TILE_SIZE) * WORDS_PER_ROW);

    assign tile_entry = tile_data[8 * (s1_col % TILES_PER_WORD) +: 8];

    always_ff @(posedge clk) begin
        if (reset || !sync_mode) begin
            state <= FETCH_IDLE;
            tile_addr <= '0;
            gfx_addr <= '0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            wr.valid <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    tile_addr <= row_base;
                    s1_valid <= 1'b1;
                    s1_col <= '0;
                    state <= FETCH_RUN;
                end
                FETCH_RUN: begin
                    // Tile word to graphics request
                    if (s1_valid) begin
                        gfx_addr <= gfx_addr_t'(tile_id_t'(tile_entry[6:0]) * TILE_SIZE
                                                + vcount % TILE_SIZE);
                        s2_col <= s1_col;
                        s2_pal <= tile_entry[7];
                    end else begin
                        gfx_addr <= '0;
                    end
                    s2_valid <= s1_valid;

                    // Issue the next column's tile word
                    if (s1_valid && s1_col != tile_col_t'(TILES_PER_LINE - 1)) begin
                        tile_addr <= row_base
                                     + tile_addr_t'((s1_col + 1'b1) / TILES_PER_WORD);
                        s1_col <= s1_col + 1'b1;
                    end else begin
                        tile_addr <= '0;
                        s1_valid <= 1'b0;
                    end

                    // Graphics row to line buffer
                    wr.valid <= s2_valid;
                    wr.col <= s2_col;
                    wr.gfx <= gfx_data;
                    wr.pal_sel <= s2_pal;

                    if (s2_valid && s2_col == tile_col_t'(TILES_PER_LINE - 1)) begin
                        state <= FETCH_DONE;
                    end
                end
                default: begin
                    // Line complete, wait for sync to end
                    wr.valid <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- rtl/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic               clk,
    input  logic               reset,
    line_wr_if.buffer          wr,
    input  ppu_pkg::tile_col_t rd_col,
    output ppu_pkg::tile_gfx_t rd_gfx,
    output logic               rd_pal_sel
);
    import ppu_pkg::*;

    tile_gfx_t gfx_mem [TILES_PER_LINE];
    logic [TILES_PER_LINE-1:0] pal_mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            pal_mem <= '0;
            for (int i = 0; i < TILES_PER_LINE; i++) begin
                gfx_mem[i] <= '0;
            end
        end else if (wr.valid) begin
            gfx_mem[wr.col] <= wr.gfx;
            pal_mem[wr.col] <= wr.pal_sel;
        end
    end

    // Registered read, columns past the line read as blank
    always_ff @(posedge clk) begin
        if (rd_col < tile_col_t'(TILES_PER_LINE)) begin
            rd_gfx <= gfx_mem[rd_col];
            rd_pal_sel <= pal_mem[rd_col];
        end else begin
            rd_gfx <= '0;
            rd_pal_sel <= 1'b0;
        end
    end

endmodule

//--- rtl/pixel_pipe.sv
`timescale 1ns/1ps

module pixel_pipe (
    input  logic               clk,
    input  logic               reset,
    input  logic               vblank,
    input  logic               hsync,
    input  ppu_pkg::hcount_t   hcount,
    input  ppu_pkg::tile_gfx_t rd_gfx,
    input  logic               rd_pal_sel,
    input  ppu_pkg::color_t    lookup_color,
    output ppu_pkg::tile_col_t rd_col,
    output ppu_pkg::pal_addr_t lookup_index,
    output ppu_pkg::color_t    pixel_color
);
    import ppu_pkg::*;

    logic [$clog2(TILE_SIZE)-1:0] pos_q;
    logic active_q;
    pixel_t pixel;

    // Stage one address, the line buffer registers the entry
    assign rd_col = tile_col_t'(hcount / TILE_SIZE);

    // Pixel position and mode travel alongside the buffer read
    always_ff @(posedge clk) begin
        if (reset) begin
            pos_q <= '0;
            active_q <= 1'b0;
        end else begin
            pos_q <= hcount[$clog2(TILE_SIZE)-1:0];
            active_q <= !vblank && !hsync;
        end
    end

    // Pixel 0 sits in the top two bits
    assign pixel = rd_gfx[2 * (TILE_SIZE - 1 - pos_q) +: 2];

    // Palette bit picks the upper or lower four cache entries
    assign lookup_index = pal_addr_t'(rd_pal_sel * COLORS_PER_PALETTE + pixel);

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else if (active_q) begin
            pixel_color <= lookup_color;
        end else begin
            pixel_color <= '0;
        end
    end

endmodule

//--- rtl/ppu_top.sv
`timescale 1ns/1ps

module ppu_top (
    input  logic                clk,
    input  logic                reset,
    input  ppu_pkg::hcount_t    hcount,
    input  ppu_pkg::vcount_t    vcount,
    input  logic                vblank,
    input  logic                hsync,
    input  ppu_pkg::tile_word_t tile_data,
    input  ppu_pkg::tile_gfx_t  gfx_data,
    input  ppu_pkg::color_t     pal_data,
    output ppu_pkg::tile_addr_t tile_addr,
    output ppu_pkg::gfx_addr_t  gfx_addr,
    output ppu_pkg::pal_addr_t  pal_addr,
    output ppu_pkg::color_t     pixel_color
);
    import ppu_pkg::*;

    // Line buffer read port
    tile_col_t rd_col;
    tile_gfx_t rd_gfx;
    logic rd_pal_sel;

    // Palette lookup port
    pal_addr_t lookup_index;
    color_t lookup_color;

    line_wr_if wr_bus ();

    palette_cache palette_cache_inst (
        .clk          (clk),
        .reset        (reset),
        .vblank       (vblank),
        .pal_data     (pal_data),
        .lookup_index (lookup_index),
        .pal_addr     (pal_addr),
        .lookup_color (lookup_color)
    );

    background_fetch background_fetch_inst (
        .clk       (clk),
        .reset     (reset),
        .vblank    (vblank),
        .hsync     (hsync),
        .vcount    (vcount),
        .tile_data (tile_data),
        .gfx_data  (gfx_data),
        .tile_addr (tile_addr),
        .gfx_addr  (gfx_addr),
        .wr        (wr_bus.fetch)
    );

    line_buffer line_buffer_inst (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr_bus.buffer),
        .rd_col     (rd_col),
        .rd_gfx     (rd_gfx),
        .rd_pal_sel (rd_pal_sel)
    );

    pixel_pipe pixel_pipe_inst (
        .clk          (clk),
        .reset        (reset),
        .vblank       (vblank),
        .hsync        (hsync),
        .hcount       (hcount),
        .rd_gfx       (rd_gfx),
        .rd_pal_sel   (rd_pal_sel),
        .lookup_color (lookup_color),
        .rd_col       (rd_col),
        .lookup_index (lookup_index),
        .pixel_color  (pixel_color)
    );

endmodule

//--- dv/ppu_checker.sv
`timescale 1ns/1ps

module ppu_checker (
    input logic                clk,
    input logic                reset,
    input logic                vblank,
    input logic                hsync,
    input ppu_pkg::tile_addr_t tile_addr,
    input ppu_pkg::gfx_addr_t  gfx_addr,
    input ppu_pkg::pal_addr_t  pal_addr,
    input ppu_pkg::color_t     pixel_color
);
    logic active;

    assign active = !vblank && !hsync;

    // Palette loader only walks its addresses during vertical blank
    pal_addr_parked_outside_blank: assert property (
        @(posedge clk) disable iff (reset) !vblank |=> pal_addr == '0
    ) else $error("pal_addr %0d not parked outside vertical blank", pal_addr);

    // Mode reaches pixel_color through two pipeline registers
    blank_after_inactive: assert property (
        @(posedge clk) disable iff (reset) $past(!active, 2) |-> pixel_color == '0
    ) else $error("pixel_color %h not blank after a non-active cycle", pixel_color);

    // Fetcher parks its addresses once sync ends
    addr_idle_in_active: assert property (
        @(posedge clk) disable iff (reset)
        active && $past(active) |-> tile_addr == '0 && gfx_addr == '0
    ) else $error("tile_addr %h gfx_addr %h not idle in active mode", tile_addr, gfx_addr);

endmodule

bind ppu_top ppu_checker ppu_checker_inst (
    .clk         (clk),
    .reset       (reset),
    .vblank      (vblank),
    .hsync       (hsync),
    .tile_addr   (tile_addr),
    .gfx_addr    (gfx_addr),
    .pal_addr    (pal_addr),
    .pixel_color (pixel_color)
);

//--- dv/ppu_tests.svh
// Outputs straight after reset
task automatic check_reset_state();
    int errs;
    errs = 0;
    if (pixel_color !== '0 || tile_addr !== '0 || gfx_addr !== '0 || pal_addr !== '0) begin
        errs++;
        $display("FAILED %0t: after reset color %h tile_addr %h gfx_addr %h pal_addr %h",
                 $time, pixel_color, tile_addr, gfx_addr, pal_addr);
    end
    record_result("reset state", errs);
endtask

// All tiles ID 0, palette 0, graphics row 0 cycles through values 0 to 3
task automatic verify_palette_load();
    int errs;
    int sweep_errs;
    errs = 0;
    scramble_palette();
    load_palette();
    if (pal_addr !== '0) begin
        errs++;
        $display("FAILED %0t: pal_addr %0d after the load, expected 0", $time, pal_addr);
    end
    for (int w = 0; w < WORDS_PER_ROW; w++) begin
        tile_mem[w] = '0;
    end
    gfx_mem[0] = {4{8'h1b}};
    for (int h = 0; h < LINE_PIXELS; h++) begin
        exp_line[h] = pal_mem[h % COLORS_PER_PALETTE];
    end
    fetch_line(10'd0);
    sweep_line(10'd0, sweep_errs);
    record_result("palette load", errs + sweep_errs);
endtask

task automatic compare_random_line();
    int errs;
    scramble_tile_memories();
    fetch_line(10'd117);
    build_expected_line(10'd117);
    sweep_line(10'd117, errs);
    record_result("full random line", errs);
endtask

// Odd columns have bit 7 set and should use entries 4 to 7
task automatic palette_select_bit();
    int errs;
    int odd_col;
    for (int w = 0; w < WORDS_PER_ROW; w++) begin
        tile_mem[w] = 32'h81018101;
    end
    gfx_mem[TILE_SIZE] = {4{8'h1b}};
    for (int h = 0; h < LINE_PIXELS; h++) begin
        odd_col = (h / TILE_SIZE) % 2;
        exp_line[h] = pal_mem[odd_col * COLORS_PER_PALETTE + h % COLORS_PER_PALETTE];
    end
    fetch_line(10'd0);
    sweep_line(10'd0, errs);
    record_result("palette select bit", errs);
endtask

task automatic row_addressing();
    vcount_t lines [3];
    int errs;
    int sweep_errs;
    // Tile row 2 at rows 3 and 10, then tile row 12 at row 8
    lines = '{10'd35, 10'd42, 10'd200};
    errs = 0;
    foreach (lines[i]) begin
        fetch_line(lines[i]);
        build_expected_line(lines[i]);
        sweep_line(lines[i], sweep_errs);
        errs += sweep_errs;
    end
    record_result("row addressing", errs);
endtask

// Line buffer still holds vcount 200
task automatic reload_palette_colors();
    int errs;
    for (int i = 0; i < PALETTE_ENTRIES; i++) begin
        pal_mem[i] = pal_mem[i] ^ (color_t'(random_bits(24)) | 24'h1);
    end
    load_palette();
    build_expected_line(10'd200);
    sweep_line(10'd200, errs);
    record_result("palette reload", errs);
endtask

//--- dv/tb_ppu_top.sv
`timescale 1ns/1ps

module tb_ppu_top;
    import ppu_pkg::*;

    localparam int HALF_PERIOD_NS = 2;
    localparam int LINE_PIXELS = TILES_PER_LINE * TILE_SIZE;
    // Full run is roughly 5000 cycles, about 20 us
    localparam int WATCHDOG_NS = 200_000;

    logic clk;
    logic reset;
    hcount_t hcount;
    vcount_t vcount;
    logic vblank;
    logic hsync;
    tile_word_t tile_data;
    tile_gfx_t gfx_data;
    color_t pal_data;
    tile_addr_t tile_addr;
    gfx_addr_t gfx_addr;
    pal_addr_t pal_addr;
    color_t pixel_color;

    // External memories, read data follows the registered address
    tile_word_t tile_mem [2**$bits(tile_addr_t)];
    tile_gfx_t gfx_mem [2**$bits(gfx_addr_t)];
    color_t pal_mem [PALETTE_ENTRIES];

    color_t exp_line [LINE_PIXELS];
    logic [31:0] lfsr_state = 32'hf16a797b;
    int tests_passed = 0;
    int tests_failed = 0;

    assign tile_data = tile_mem[tile_addr];
    assign gfx_data = gfx_mem[gfx_addr];
    assign pal_data = pal_mem[pal_addr];

    ppu_top ppu_top_inst (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .vblank      (vblank),
        .hsync       (hsync),
        .tile_data   (tile_data),
        .gfx_data    (gfx_data),
        .pal_data    (pal_data),
        .tile_addr   (tile_addr),
        .gfx_addr    (gfx_addr),
        .pal_addr    (pal_addr),
        .pixel_color (pixel_color)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic void scramble_palette();
        for (int i = 0; i < PALETTE_ENTRIES; i++) begin
            pal_mem[i] = color_t'(random_bits(24));
        end
    endfunction

    function automatic void scramble_tile_memories();
        foreach (tile_mem[i]) begin
            tile_mem[i] = random_bits(32);
        end
        foreach (gfx_mem[i]) begin
            gfx_mem[i] = random_bits(32);
        end
    endfunction

    // Color of one screen position straight from the memory arrays
    function automatic color_t expected_color(input hcount_t h, input vcount_t v);
        tile_col_t col;
        tile_word_t tile_word;
        logic [7:0] entry;
        tile_gfx_t row_bits;
        pixel_t pix;
        col = tile_col_t'(h / TILE_SIZE);
        tile_word = tile_mem[tile_addr_t'((v / TILE_SIZE) * WORDS_PER_ROW
                                          + col / TILES_PER_WORD)];
        entry = tile_word[8 * (col % TILES_PER_WORD) +: 8];
        // Tile ID times 16 plus the row inside the tile
        row_bits = gfx_mem[{entry[6:0], v[3:0]}];
        pix = row_bits[2 * (TILE_SIZE - 1 - h % TILE_SIZE) +: 2];
        return pal_mem[{entry[7], pix}];
    endfunction

    function automatic void build_expected_line(input vcount_t v);
        for (int h = 0; h < LINE_PIXELS; h++) begin
            exp_line[h] = expected_color(hcount_t'(h), v);
        end
    endfunction

    task automatic load_palette();
        hsync = 1'b0;
        vblank = 1'b1;
        repeat (12) @(posedge clk);
        #1;
        vblank = 1'b0;
    endtask

    // Fetch completes by the 42nd edge of sync
    task automatic fetch_line(input vcount_t v);
        vcount = v;
        hcount = '0;
        hsync = 1'b1;
        repeat (50) @(posedge clk);
        #1;
        hsync = 1'b0;
    endtask

    // Each hcount shows up on pixel_color two edges later
    task automatic sweep_line(input vcount_t v, output int errs);
        errs = 0;
        vblank = 1'b0;
        hsync = 1'b0;
        for (int j = 0; j < LINE_PIXELS + 2; j++) begin
            if (j >= 2 && pixel_color !== exp_line[j - 2]) begin
                errs++;
                $display("FAILED %0t: hcount %0d vcount %0d color %h expected %h",
                         $time, j - 2, v, pixel_color, exp_line[j - 2]);
            end
            hcount = (j < LINE_PIXELS) ? hcount_t'(j) : '0;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic record_result(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errs);
        end
    endtask

    `include "ppu_tests.svh"

    initial begin
        reset = 1'b1;
        hcount = '0;
        vcount = '0;
        vblank = 1'b0;
        hsync = 1'b0;
        scramble_palette();
        scramble_tile_memories();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        verify_palette_load();
        compare_random_line();
        palette_select_bit();
        row_addressing();
        reload_palette_colors();
        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout, the tests did not complete in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- ppu_top.f
+incdir+dv
rtl/ppu_pkg.sv
rtl/line_wr_if.sv
rtl/palette_cache.sv
rtl/background_fetch.sv
rtl/line_buffer.sv
rtl/pixel_pipe.sv
rtl/ppu_top.sv
dv/ppu_checker.sv
dv/tb_ppu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PPU background testbench with Verilator
cd "$(dirname "$0")" || exit 1

sim_out=$(verilator --binary --timing --assert -j 0 --top-module tb_ppu_top -f ppu_top.f \
    && ./obj_dir/Vtb_ppu_top) || { echo "$sim_out"; echo "Build or simulation failed"; exit 1; }

echo "$sim_out"
echo "$sim_out" | grep -q "ALL TESTS PASSED" && exit 0 || { echo "Simulation reported failures"; exit 1; }
